// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

	// CPU request code, held by the CPU for a whole transaction
	// Code 2 is unused and treated as IDLE
	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		READ  = 2'b01,
		WRITE = 2'b11
	} opcode_e;

	// Controller FSM states
	typedef enum logic [1:0] {
		STARTUP = 2'b00,
		READY   = 2'b01,
		HOSTOP  = 2'b10,
		FILL    = 2'b11
	} mem_state_e;

	// Strobes and levels toward the host DMA port
	typedef struct packed {
		// Read go level, held while waiting for a host line
		logic rgo;
		// Write go level, held while waiting to hand off a line
		logic wgo;
		// One strobe per word handed to the CPU on a read
		logic re;
		// Single strobe when the line is handed to the host
		logic we;
	} host_ctrl_t;

	// Status toward the CPU
	typedef struct packed {
		logic ready;
		logic tx_done;
		logic rd_valid;
	} cpu_status_t;

endpackage

`default_nettype wire

// File: line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
	parameter int WORD_SIZE     = 32,
	parameter int CL_SIZE_WIDTH = 512,
	// Derived from the two widths above, not meant to be overridden
	parameter int FILL_BITS     = $clog2(CL_SIZE_WIDTH / WORD_SIZE)
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      shift_en,
	input  wire                      load_en,
	input  wire  [FILL_BITS-1:0]     word_index,
	input  wire  [WORD_SIZE-1:0]     shift_word,
	input  wire  [CL_SIZE_WIDTH-1:0] load_line,
	output logic [CL_SIZE_WIDTH-1:0] line,
	output logic [WORD_SIZE-1:0]     word_out
);

	localparam int FILL_COUNT = CL_SIZE_WIDTH / WORD_SIZE;

	// Line register
	// Word k sits at bits k*WORD_SIZE upward
	logic [CL_SIZE_WIDTH-1:0] line_q;

	// Word view of the line for output selection
	logic [WORD_SIZE-1:0] words [FILL_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_q <= '0;
		end else if (load_en) begin
			// Full host line in one edge
			line_q <= load_line;
		end else if (shift_en) begin
			// New CPU word enters at the top, older words move down
			// After FILL_COUNT shifts the first word is at word 0
			line_q <= {shift_word, line_q[CL_SIZE_WIDTH-1:WORD_SIZE]};
		end
	end

	// Split the line into words
	for (genvar gi = 0; gi < FILL_COUNT; gi++) begin : g_words
		assign words[gi] = line_q[gi*WORD_SIZE +: WORD_SIZE];
	end

	// Word mux for the CPU read path
	assign word_out = words[word_index];

	// Whole line goes straight to the host write bus
	assign line = line_q;

endmodule

`default_nettype wire

// File: mem_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ctrl #(
	parameter int WORD_SIZE     = 32,
	parameter int CL_SIZE_WIDTH = 512,
	parameter int ADDR_BITCOUNT = 64
) (
	input  wire                      clk,
	input  wire                      rst_n,
	// Host control inputs
	input  wire                      host_init,
	input  wire                      host_rd_ready,
	input  wire                      host_wr_ready,
	// CPU request
	input  wire mem_pkg::opcode_e    op,
	input  wire  [ADDR_BITCOUNT-1:0] raw_address,
	input  wire  [ADDR_BITCOUNT-1:0] address_offset,
	input  wire  [WORD_SIZE-1:0]     cpu_wdata,
	input  wire  [CL_SIZE_WIDTH-1:0] host_rdata,
	output logic [WORD_SIZE-1:0]     cpu_rdata,
	output logic [CL_SIZE_WIDTH-1:0] host_wdata,
	output logic [ADDR_BITCOUNT-1:0] corrected_address,
	output mem_pkg::cpu_status_t     status,
	output mem_pkg::host_ctrl_t      host
);

	localparam int FILL_COUNT = CL_SIZE_WIDTH / WORD_SIZE;
	localparam int FILL_BITS  = $clog2(FILL_COUNT);

	mem_pkg::opcode_e    op_in;
	mem_pkg::mem_state_e state;

	// Word counter for both the CPU fill and the CPU drain
	logic [FILL_BITS-1:0] fill_count;
	logic                 fill_last;

	// Set after the first HOSTOP cycle of a write
	// Gives the corrected address one cycle to settle at the host
	logic bubble;

	// Line buffer controls
	logic shift_en;
	logic load_en;

	// Opcode decode, the unused code folds into IDLE
	always_comb begin
		case (op)
			mem_pkg::READ:  op_in = mem_pkg::READ;
			mem_pkg::WRITE: op_in = mem_pkg::WRITE;
			default:        op_in = mem_pkg::IDLE;
		endcase
	end

	assign fill_last = &fill_count;

	// Capture a CPU word every FILL cycle of a write
	assign shift_en = (state == mem_pkg::FILL) && (op_in == mem_pkg::WRITE);
	// Take the host line on the first ready edge of a read
	assign load_en = (state == mem_pkg::HOSTOP) && (op_in == mem_pkg::READ) && host_rd_ready;

	// Output decode per state
	always_comb begin
		status.ready    = (state != mem_pkg::STARTUP);
		status.tx_done  = 1'b0;
		status.rd_valid = 1'b0;
		host.rgo        = 1'b0;
		host.wgo        = 1'b0;
		host.re         = 1'b0;
		host.we         = 1'b0;

		case (state)
			mem_pkg::HOSTOP: begin
				if (op_in == mem_pkg::WRITE) begin
					host.wgo = 1'b1;
					// Hand off only once the bubble has passed
					if (bubble && host_wr_ready) begin
						host.we        = 1'b1;
						status.tx_done = 1'b1;
					end
				end else if (op_in == mem_pkg::READ) begin
					host.rgo = 1'b1;
				end
			end
			mem_pkg::FILL: begin
				if (op_in == mem_pkg::READ) begin
					// One word per cycle toward the CPU
					host.re         = 1'b1;
					status.rd_valid = 1'b1;
					status.tx_done  = fill_last;
				end
			end
			default: begin
			end
		endcase
	end

	// FSM, fill counter and bubble flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= mem_pkg::STARTUP;
			fill_count <= '0;
			bubble     <= 1'b0;
		end else begin
			case (state)
				mem_pkg::STARTUP: begin
					// Ops are ignored until the host is up
					if (host_init) begin
						state <= mem_pkg::READY;
					end
				end
				mem_pkg::READY: begin
					if (op_in == mem_pkg::READ) begin
						state <= mem_pkg::HOSTOP;
					end else if (op_in == mem_pkg::WRITE) begin
						state <= mem_pkg::FILL;
					end
				end
				mem_pkg::FILL: begin
					fill_count <= fill_count + 1'b1;
					if (fill_last) begin
						fill_count <= '0;
						// Full line collected goes to the host, drained line ends the read
						state <= (op_in == mem_pkg::WRITE) ? mem_pkg::HOSTOP : mem_pkg::READY;
					end
				end
				mem_pkg::HOSTOP: begin
					if (op_in == mem_pkg::READ) begin
						if (host_rd_ready) begin
							state <= mem_pkg::FILL;
						end
					end else if (op_in == mem_pkg::WRITE) begin
						if (!bubble) begin
							bubble <= 1'b1;
						end else if (host_wr_ready) begin
							bubble <= 1'b0;
							state  <= mem_pkg::READY;
						end
					end else begin
						// CPU dropped the op mid transaction
						bubble <= 1'b0;
						state  <= mem_pkg::READY;
					end
				end
				default: begin
					state <= mem_pkg::STARTUP;
				end
			endcase
		end
	end

	// Host sees the CPU address shifted into its own space
	assign corrected_address = raw_address + address_offset;

	line_buffer #(
		.WORD_SIZE     (WORD_SIZE),
		.CL_SIZE_WIDTH (CL_SIZE_WIDTH)
	) u_line_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.shift_en   (shift_en),
		.load_en    (load_en),
		.word_index (fill_count),
		.shift_word (cpu_wdata),
		.load_line  (host_rdata),
		.line       (host_wdata),
		.word_out   (cpu_rdata)
	);

endmodule

`default_nettype wire

// File: mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys #(
	// CPU word width
	parameter int WORD_SIZE     = 32,
	// Cache line width, a power-of-two multiple of the word
	parameter int CL_SIZE_WIDTH = 512,
	parameter int ADDR_BITCOUNT = 64
) (
	input  wire                      clk,
	input  wire                      rst_n,
	// Host side inputs
	input  wire                      host_init,
	input  wire                      host_rd_ready,
	input  wire                      host_wr_ready,
	input  wire  [ADDR_BITCOUNT-1:0] address_offset,
	input  wire  [CL_SIZE_WIDTH-1:0] host_rdata,
	// CPU side inputs
	input  wire mem_pkg::opcode_e    op,
	input  wire  [ADDR_BITCOUNT-1:0] raw_address,
	input  wire  [WORD_SIZE-1:0]     cpu_wdata,
	// CPU side outputs
	output logic [WORD_SIZE-1:0]     cpu_rdata,
	output mem_pkg::cpu_status_t     status,
	// Host side outputs
	output logic [CL_SIZE_WIDTH-1:0] host_wdata,
	output logic [ADDR_BITCOUNT-1:0] corrected_address,
	output mem_pkg::host_ctrl_t      host
);

	// Controller with its line buffer
	mem_ctrl #(
		.WORD_SIZE     (WORD_SIZE),
		.CL_SIZE_WIDTH (CL_SIZE_WIDTH),
		.ADDR_BITCOUNT (ADDR_BITCOUNT)
	) u_mem_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.host_init         (host_init),
		.host_rd_ready     (host_rd_ready),
		.host_wr_ready     (host_wr_ready),
		.op                (op),
		.raw_address       (raw_address),
		.address_offset    (address_offset),
		.cpu_wdata         (cpu_wdata),
		.host_rdata        (host_rdata),
		.cpu_rdata         (cpu_rdata),
		.host_wdata        (host_wdata),
		.corrected_address (corrected_address),
		.status            (status),
		.host              (host)
	);

endmodule

`default_nettype wire

// File: tb_host_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_host_model #(
	parameter int CL_SIZE_WIDTH = 512,
	parameter int ADDR_BITCOUNT = 64
) (
	input  wire                      clk,
	// Asks for the one-cycle init pulse
	input  wire                      init_req,
	// Keeps both ready lines low while set
	input  wire                      stall,
	input  wire mem_pkg::host_ctrl_t host,
	input  wire  [ADDR_BITCOUNT-1:0] corrected_address,
	input  wire  [CL_SIZE_WIDTH-1:0] host_wdata,
	output logic                     host_init,
	output logic                     host_rd_ready,
	output logic                     host_wr_ready,
	output logic [CL_SIZE_WIDTH-1:0] host_rdata
);

	// Line memory keyed by corrected address
	logic [CL_SIZE_WIDTH-1:0] lines [logic [ADDR_BITCOUNT-1:0]];
	logic [ADDR_BITCOUNT-1:0] addr_s;
	logic go_rd, go_wr, taken, init_s, stall_s;
	logic init_sent;
	int   wait_cycles;

	function automatic logic [CL_SIZE_WIDTH-1:0] random_line();
		logic [CL_SIZE_WIDTH-1:0] l;
		for (int i = 0; i < CL_SIZE_WIDTH / 32; i++) begin
			l[i*32 +: 32] = $urandom;
		end
		return l;
	endfunction

	initial begin
		host_init     = 1'b0;
		host_rd_ready = 1'b0;
		host_wr_ready = 1'b0;
		host_rdata    = '0;
		init_sent     = 1'b0;
		wait_cycles   = -1;
		forever begin
			// Sample strobes, address and requests on the edge
			@(posedge clk);
			taken   = (host.rgo && host_rd_ready) || host.we;
			addr_s  = corrected_address;
			init_s  = init_req;
			stall_s = stall;
			if (host.we) begin
				lines[addr_s] = host_wdata;
			end
			// Drive 1 ns later
			#1;
			// Go levels of the cycle just started
			// A zero delay answers in the first HOSTOP cycle, bubble included
			go_rd     = host.rgo;
			go_wr     = host.wgo;
			host_init = init_s && !init_sent;
			init_sent = init_sent || init_s;
			if (taken || !(go_rd || go_wr)) begin
				host_rd_ready = 1'b0;
				host_wr_ready = 1'b0;
				wait_cycles   = -1;
			end else if (!host_rd_ready && !host_wr_ready) begin
				// New random delay for each request
				if (wait_cycles < 0) begin
					wait_cycles = $urandom_range(0, 5);
				end
				if (wait_cycles > 0) begin
					wait_cycles--;
				end else if (!stall_s) begin
					if (go_rd) begin
						// Unknown lines get random contents on first touch
						if (!lines.exists(addr_s)) begin
							lines[addr_s] = random_line();
						end
						host_rdata    = lines[addr_s];
						host_rd_ready = 1'b1;
					end else begin
						host_wr_ready = 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;

	localparam int WORD_SIZE     = 32;
	localparam int CL_SIZE_WIDTH = 512;
	localparam int ADDR_BITCOUNT = 64;
	localparam int FILL_COUNT    = CL_SIZE_WIDTH / WORD_SIZE;
	// Roughly 1100 cycles for all tests at the longest host delays, with margin
	localparam int MAX_CYCLES    = 4000;

	logic clk, rst_n;
	logic host_init, host_rd_ready, host_wr_ready;
	logic init_req, stall;
	mem_pkg::opcode_e         op;
	logic [ADDR_BITCOUNT-1:0] raw_address, address_offset, corrected_address;
	logic [WORD_SIZE-1:0]     cpu_wdata, cpu_rdata;
	logic [CL_SIZE_WIDTH-1:0] host_rdata, host_wdata;
	mem_pkg::cpu_status_t     status;
	mem_pkg::host_ctrl_t      host;

	// Scoreboard of expected lines by corrected address
	logic [CL_SIZE_WIDTH-1:0] expected_lines [logic [ADDR_BITCOUNT-1:0]];
	int errors       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int we_pulses    = 0;
	int cycle_count  = 0;

	mem_subsys #(
		.WORD_SIZE     (WORD_SIZE),
		.CL_SIZE_WIDTH (CL_SIZE_WIDTH),
		.ADDR_BITCOUNT (ADDR_BITCOUNT)
	) dut (.*);

	tb_host_model #(
		.CL_SIZE_WIDTH (CL_SIZE_WIDTH),
		.ADDR_BITCOUNT (ADDR_BITCOUNT)
	) host_model (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_error(input string msg);
		$display("** Error: %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name, input int errors_at_start);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%0t ns: test %s ok", $time, name);
		end else begin
			tests_failed++;
			$display("%0t ns: test %s had %0d errors", $time, name, errors - errors_at_start);
		end
	endtask

	// Port rules that hold on every edge
	always @(posedge clk) begin
		if (rst_n) begin
			assert (corrected_address == raw_address + address_offset)
				else report_error("corrected_address is not raw_address plus address_offset");
			assert (status.rd_valid == host.re) else report_error("rd_valid and re differ");
			assert (!(host.rgo && host.wgo)) else report_error("rgo and wgo high together");
			if (host.we) begin
				we_pulses++;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) host.we |-> host.wgo && status.tx_done)
		else report_error("we without wgo and tx_done");
	assert property (@(posedge clk) disable iff (!rst_n) host_init && !status.ready |=> status.ready)
		else report_error("ready did not rise the cycle after host_init");

	// Op held at READ, init requested after a few idle cycles
	task automatic check_startup();
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(posedge clk);
			assert (!status.ready && host == '0 && !status.tx_done && !status.rd_valid)
				else report_error("ready or a host strobe rose before host_init");
			if (host_init) begin
				seen = 1'b1;
			end else begin
				cycles++;
				if (cycles == 6) begin
					#1;
					init_req = 1'b1;
				end
			end
		end
		#1;
		op = mem_pkg::IDLE;
		@(posedge clk);
		assert (status.ready) else report_error("ready low the cycle after host_init");
	endtask

	// One line write or read, hold > 0 keeps the host stalled that many HOSTOP cycles
	task automatic transfer(input logic write, input logic [ADDR_BITCOUNT-1:0] addr,
			input logic [ADDR_BITCOUNT-1:0] offs, input int hold);
		logic [CL_SIZE_WIDTH-1:0] line_exp;
		logic [ADDR_BITCOUNT-1:0] key;
		logic [WORD_SIZE-1:0]     word;
		int                       waited;
		int                       pulses;
		logic                     done;
		@(posedge clk);
		#1;
		op             = write ? mem_pkg::WRITE : mem_pkg::READ;
		raw_address    = addr;
		address_offset = offs;
		stall          = (hold > 0);
		key            = addr + offs;
		pulses         = we_pulses;
		if (write) begin
			// Word k in the k-th FILL cycle, word k lands at bits k*WORD_SIZE
			for (int k = 0; k < FILL_COUNT; k++) begin
				word = WORD_SIZE'($urandom);
				line_exp[k*WORD_SIZE +: WORD_SIZE] = word;
				@(posedge clk);
				#1;
				cpu_wdata = word;
			end
		end
		// Edge that leaves READY or the last FILL cycle
		@(posedge clk);
		waited = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge clk);
			done = write ? host.we : (host.rgo && host_rd_ready);
			if (!done) begin
				waited++;
				assert ((write ? host.wgo : host.rgo) && !host.we && !status.rd_valid
						&& !status.tx_done)
					else report_error("go level dropped or status moved while host not ready");
				if (stall && waited == hold) begin
					#1;
					stall = 1'b0;
				end
			end
		end
		if (write) begin
			// Bubble means at least one wgo cycle before we
			assert (host_wdata == line_exp && status.tx_done && waited > 0)
				else report_error("host_wdata, tx_done or the wgo bubble wrong at we");
			expected_lines[key] = line_exp;
		end else begin
			// Never written lines hold whatever the host had
			if (!expected_lines.exists(key)) begin
				expected_lines[key] = host_rdata;
			end
			line_exp = expected_lines[key];
			for (int k = 0; k < FILL_COUNT; k++) begin
				@(posedge clk);
				word = line_exp[k*WORD_SIZE +: WORD_SIZE];
				assert (status.rd_valid && host.re && cpu_rdata == word
						&& status.tx_done == (k == FILL_COUNT - 1))
					else report_error($sformatf("read word %0d: got %h expected %h, tx_done %b",
						k, cpu_rdata, word, status.tx_done));
			end
		end
		#1;
		op = mem_pkg::IDLE;
		@(posedge clk);
		assert (!status.rd_valid && !host.we && we_pulses == pulses + (write ? 1 : 0))
			else report_error("rd_valid or an extra we after the transfer");
	endtask

	initial begin
		int start;
		void'($urandom(32'h315f9008));
		rst_n          = 1'b0;
		op             = mem_pkg::READ;
		raw_address    = '0;
		address_offset = '0;
		cpu_wdata      = '0;
		init_req       = 1'b0;
		stall          = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		start = errors;
		check_startup();
		end_test("startup", start);

		// Offset wraps past the top of the address space to 0x40
		start = errors;
		transfer(1'b1, 64'hFFFF_FFFF_FFFF_FFC0, 64'h80, 0);
		end_test("line write", start);

		// Same corrected address through another raw/offset pair
		start = errors;
		transfer(1'b0, 64'h0, 64'h40, 0);
		end_test("line read", start);

		start = errors;
		transfer(1'b0, 64'h1000, 64'h0, 24);
		transfer(1'b1, 64'h2000, 64'h40, 24);
		end_test("back-pressure", start);

		// Small address and offset pools so lines get reused
		start = errors;
		for (int i = 0; i < 30; i++) begin
			transfer(1'($urandom_range(0, 1)), ADDR_BITCOUNT'($urandom_range(0, 7) * 64),
				ADDR_BITCOUNT'($urandom_range(0, 3) * 64), 0);
		end
		end_test("random mix", start);

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
mem_pkg.sv
line_buffer.sv
mem_ctrl.sv
mem_subsys.sv
tb_host_model.sv
tb_mem_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_subsys)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
